// ==== rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data path width
`define RV_XLEN 32

// Instruction word width
`define RV_ILEN 32

// RV32E register count with x0 included
`define RV_NREGS 16
`define RV_REG_AW 4

// Shift amount width is log2 of RV_XLEN
`define RV_SHAMT_W 5

`endif

// ==== rv_pkg.sv ====
`default_nettype none
`include "rv_core_config.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011,
    OPC_FENCE  = 7'b0001111
  } opcode_e;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_op_e;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    logic [`RV_XLEN-1:0]   imm;       // JALR carries rs1 + offset here
    logic [`RV_REG_AW-1:0] rd;
    alu_op_e               alu_op;
    br_op_e                br_op;
    logic                  link;      // Write PC+4
    logic                  is_branch;
    logic                  is_jump;
    logic                  jump_reg;  // JALR
    logic                  wen;
    logic                  illegal;
  } dec_pkt_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   wdata;
    logic                  wen;
    logic                  taken;
    logic [`RV_XLEN-1:0]   target;
    logic                  illegal;
  } exe_pkt_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   wdata;
    logic                  wen;
    logic                  taken;
    logic [`RV_XLEN-1:0]   target;
    logic                  illegal;
  } retire_t;

endpackage

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module rv_regfile (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [`RV_REG_AW-1:0] raddr1_i,
  input  wire  [`RV_REG_AW-1:0] raddr2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  output logic                  busy1_o,
  output logic                  busy2_o,
  input  wire                   set_busy_i,
  input  wire  [`RV_REG_AW-1:0] set_addr_i,
  input  wire                   wen_i,
  input  wire  [`RV_REG_AW-1:0] waddr_i,
  input  wire  [`RV_XLEN-1:0]   wdata_i
);
  logic [`RV_XLEN-1:0]  regs [1:`RV_NREGS-1]; // No storage for x0
  logic [`RV_NREGS-1:0] busy;

  always_ff @(posedge clk) begin
    if (wen_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // One pending writer per register
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (wen_i) begin
        busy[waddr_i] <= 1'b0;
      end
      if (set_busy_i && set_addr_i != '0) begin
        busy[set_addr_i] <= 1'b1; // Set overrides same-edge clear
      end
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
  assign busy1_o  = busy[raddr1_i]; // busy[0] never set
  assign busy2_o  = busy[raddr2_i];

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module rv_decode (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [`RV_ILEN-1:0]   inst_i,
  input  wire  [`RV_XLEN-1:0]   pc_i,
  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  output logic [`RV_REG_AW-1:0] rs1_o,
  output logic [`RV_REG_AW-1:0] rs2_o,
  input  wire  [`RV_XLEN-1:0]   rdata1_i,
  input  wire  [`RV_XLEN-1:0]   rdata2_i,
  input  wire                   busy1_i,
  input  wire                   busy2_i,
  output logic                  set_busy_o,
  output logic [`RV_REG_AW-1:0] set_addr_o,
  output rv_pkg::dec_pkt_t      dec_o,
  output logic                  dec_valid_o,
  input  wire                   exe_ready_i
);
  import rv_pkg::*;

  logic [`RV_ILEN-1:0]   inst_q;
  logic [`RV_XLEN-1:0]   pc_q;
  logic                  valid_q;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   imm_i;
  logic [`RV_XLEN-1:0]   imm_b;
  logic [`RV_XLEN-1:0]   imm_u;
  logic [`RV_XLEN-1:0]   imm_j;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  writes_rd;
  logic                  hazard;
  logic                  issue;
  dec_pkt_t              pkt;

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  assign opcode = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign rd     = inst_q[7 +: `RV_REG_AW]; // RV32E uses the low 4 index bits
  assign rs1_o  = inst_q[15 +: `RV_REG_AW];
  assign rs2_o  = inst_q[20 +: `RV_REG_AW];

  assign imm_i = {{(`RV_XLEN-12){inst_q[31]}}, inst_q[31:20]};
  assign imm_b = {{(`RV_XLEN-13){inst_q[31]}}, inst_q[31], inst_q[7],
                  inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst_q[31]}}, inst_q[31], inst_q[19:12],
                  inst_q[20], inst_q[30:21], 1'b0};

  always_comb begin
    pkt        = '0;
    pkt.pc     = pc_q;
    pkt.rd     = rd;
    pkt.alu_op = ALU_ADD;
    pkt.br_op  = br_op_e'(funct3);
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    writes_rd  = 1'b0;
    case (opcode)
      OPC_LUI: begin
        pkt.op2   = imm_u;
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        pkt.op1   = pc_q;
        pkt.op2   = imm_u;
        writes_rd = 1'b1;
      end
      OPC_JAL: begin
        pkt.op1     = pc_q;
        pkt.op2     = `RV_XLEN'd4;
        pkt.imm     = imm_j;
        pkt.link    = 1'b1;
        pkt.is_jump = 1'b1;
        writes_rd   = 1'b1;
      end
      OPC_JALR: begin
        pkt.op1      = pc_q;
        pkt.op2      = `RV_XLEN'd4;
        pkt.imm      = rdata1_i + imm_i; // Target base
        pkt.link     = 1'b1;
        pkt.is_jump  = 1'b1;
        pkt.jump_reg = 1'b1;
        pkt.illegal  = (funct3 != 3'b000);
        use_rs1      = 1'b1;
        writes_rd    = 1'b1;
      end
      OPC_BRANCH: begin
        pkt.op1       = rdata1_i;
        pkt.op2       = rdata2_i;
        pkt.imm       = imm_b;
        pkt.is_branch = 1'b1;
        pkt.illegal   = (funct3[2:1] == 2'b01);
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
      end
      OPC_OP_IMM: begin
        pkt.op1     = rdata1_i;
        pkt.op2     = imm_i;
        pkt.imm     = imm_i;
        pkt.alu_op  = alu_op_e'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
        pkt.illegal = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
                      (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000);
        use_rs1     = 1'b1;
        writes_rd   = 1'b1;
      end
      OPC_OP: begin
        pkt.op1     = rdata1_i;
        pkt.op2     = rdata2_i;
        pkt.alu_op  = alu_op_e'({funct7[5], funct3});
        pkt.illegal = (funct7 != 7'b0000000 && funct7 != 7'b0100000) ||
                      (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101);
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        writes_rd   = 1'b1;
      end
      default: begin
        pkt.illegal = 1'b1; // Loads, stores, SYSTEM, FENCE, unknown
      end
    endcase
    if (pkt.illegal) begin
      pkt.is_branch = 1'b0;
      pkt.is_jump   = 1'b0;
      pkt.link      = 1'b0;
    end
    pkt.wen = writes_rd && !pkt.illegal && (rd != '0);
  end

  assign hazard      = (use_rs1 && busy1_i) || (use_rs2 && busy2_i);
  assign dec_valid_o = valid_q && !hazard;
  assign issue       = dec_valid_o && exe_ready_i;
  assign in_ready_o  = !valid_q || issue;
  assign dec_o       = pkt;
  assign set_busy_o  = issue && pkt.wen;
  assign set_addr_o  = rd;

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module rv_execute (
  input  wire              clk,
  input  wire              rst,
  input  wire              rv_pkg::dec_pkt_t dec_i,
  input  wire              dec_valid_i,
  output logic             exe_ready_o,
  output rv_pkg::exe_pkt_t exe_o,
  output logic             exe_valid_o,
  input  wire              res_ready_i
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0]    alu_res;
  logic [`RV_XLEN-1:0]    pc_seq;
  logic [`RV_XLEN-1:0]    jump_target;
  logic [`RV_SHAMT_W-1:0] shamt;
  logic                   eq;
  logic                   lt;
  logic                   ltu;
  logic                   cond;
  logic                   taken;
  exe_pkt_t               exe_d;
  exe_pkt_t               exe_q;
  logic                   valid_q;

  assign shamt = dec_i.op2[`RV_SHAMT_W-1:0];
  assign eq    = (dec_i.op1 == dec_i.op2);
  assign lt    = ($signed(dec_i.op1) < $signed(dec_i.op2)); // Shared by SLT and branches
  assign ltu   = (dec_i.op1 < dec_i.op2);

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:  alu_res = dec_i.op1 + dec_i.op2;
      ALU_SUB:  alu_res = dec_i.op1 - dec_i.op2;
      ALU_SLL:  alu_res = dec_i.op1 << shamt;
      ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, lt};
      ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, ltu};
      ALU_XOR:  alu_res = dec_i.op1 ^ dec_i.op2;
      ALU_SRL:  alu_res = dec_i.op1 >> shamt;
      ALU_SRA:  alu_res = $signed(dec_i.op1) >>> shamt;
      ALU_OR:   alu_res = dec_i.op1 | dec_i.op2;
      ALU_AND:  alu_res = dec_i.op1 & dec_i.op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (dec_i.br_op)
      BR_BEQ:  cond = eq;
      BR_BNE:  cond = !eq;
      BR_BLT:  cond = lt;
      BR_BGE:  cond = !lt;
      BR_BLTU: cond = ltu;
      BR_BGEU: cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign pc_seq      = dec_i.pc + `RV_XLEN'd4;
  assign taken       = dec_i.is_jump || (dec_i.is_branch && cond);
  assign jump_target = dec_i.jump_reg ? {dec_i.imm[`RV_XLEN-1:1], 1'b0}
                                      : dec_i.pc + dec_i.imm;

  always_comb begin
    exe_d.pc      = dec_i.pc;
    exe_d.rd      = dec_i.rd;
    exe_d.wdata   = dec_i.link ? pc_seq : alu_res;
    exe_d.wen     = dec_i.wen;
    exe_d.taken   = taken;
    exe_d.target  = taken ? jump_target : pc_seq;
    exe_d.illegal = dec_i.illegal;
  end

  assign exe_ready_o = !valid_q || res_ready_i;

  always_ff @(posedge clk) begin
    if (dec_valid_i && exe_ready_o) begin
      exe_q <= exe_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (exe_ready_o) begin
      valid_q <= dec_valid_i;
    end
  end

  assign exe_o       = exe_q;
  assign exe_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== rv_result.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module rv_result (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   rv_pkg::exe_pkt_t exe_i,
  input  wire                   exe_valid_i,
  output logic                  res_ready_o,
  output logic                  rf_wen_o,
  output logic [`RV_REG_AW-1:0] rf_waddr_o,
  output logic [`RV_XLEN-1:0]   rf_wdata_o,
  output rv_pkg::retire_t       retire_o,
  output logic                  retire_valid_o,
  input  wire                   retire_ready_i
);
  import rv_pkg::*;

  retire_t ret_q;
  logic    valid_q;
  logic    retire_fire;

  assign res_ready_o = !valid_q || retire_ready_i;
  assign retire_fire = valid_q && retire_ready_i;

  always_ff @(posedge clk) begin
    if (exe_valid_i && res_ready_o) begin
      ret_q.pc      <= exe_i.pc;
      ret_q.rd      <= exe_i.rd;
      ret_q.wdata   <= exe_i.wdata;
      ret_q.wen     <= exe_i.wen;
      ret_q.taken   <= exe_i.taken;
      ret_q.target  <= exe_i.target;
      ret_q.illegal <= exe_i.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (res_ready_o) begin
      valid_q <= exe_valid_i;
    end
  end

  // Writeback and scoreboard release happen on the retire handshake
  assign rf_wen_o   = retire_fire && ret_q.wen && (ret_q.rd != '0);
  assign rf_waddr_o = ret_q.rd;
  assign rf_wdata_o = ret_q.wdata;

  assign retire_o       = ret_q;
  assign retire_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== rv_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core_top (
  input  wire                 clk,
  input  wire                 rst,
  input  wire  [`RV_ILEN-1:0] inst_i,
  input  wire  [`RV_XLEN-1:0] pc_i,
  input  wire                 in_valid_i,
  output logic                in_ready_o,
  output rv_pkg::retire_t     retire_o,
  output logic                retire_valid_o,
  input  wire                 retire_ready_i
);
  import rv_pkg::*;

  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  logic                  busy1;
  logic                  busy2;
  logic                  set_busy;
  logic [`RV_REG_AW-1:0] set_addr;
  logic                  rf_wen;
  logic [`RV_REG_AW-1:0] rf_waddr;
  logic [`RV_XLEN-1:0]   rf_wdata;
  dec_pkt_t              dec_pkt;
  logic                  dec_valid;
  logic                  exe_ready;
  exe_pkt_t              exe_pkt;
  logic                  exe_valid;
  logic                  res_ready;

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .raddr1_i   (rs1),
    .raddr2_i   (rs2),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .busy1_o    (busy1),
    .busy2_o    (busy2),
    .set_busy_i (set_busy),
    .set_addr_i (set_addr),
    .wen_i      (rf_wen),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata)
  );

  rv_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rdata1_i    (rdata1),
    .rdata2_i    (rdata2),
    .busy1_i     (busy1),
    .busy2_i     (busy2),
    .set_busy_o  (set_busy),
    .set_addr_o  (set_addr),
    .dec_o       (dec_pkt),
    .dec_valid_o (dec_valid),
    .exe_ready_i (exe_ready)
  );

  rv_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .dec_i       (dec_pkt),
    .dec_valid_i (dec_valid),
    .exe_ready_o (exe_ready),
    .exe_o       (exe_pkt),
    .exe_valid_o (exe_valid),
    .res_ready_i (res_ready)
  );

  rv_result u_result (
    .clk            (clk),
    .rst            (rst),
    .exe_i          (exe_pkt),
    .exe_valid_i    (exe_valid),
    .res_ready_o    (res_ready),
    .rf_wen_o       (rf_wen),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .retire_o       (retire_o),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb_rv_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module tb_rv_checker (
  input  wire             clk,
  input  wire             rst,
  input  wire             rv_pkg::retire_t retire_i,
  input  wire             retire_valid_i,
  input  wire             retire_ready_i,
  output int              pass_count_o,
  output int              fail_count_o,
  output int              checked_o
);
  import rv_pkg::*;

  retire_t exp_q [$];
  retire_t exp_rec;
  int      errors;

  task automatic add_expected(input retire_t rec);
    exp_q.push_back(rec);
  endtask

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int rec_no);
    if (actual !== expected) begin
      $display("ERROR record %0d: %s expected %h got %h", rec_no, name, expected, actual);
      errors++;
    end
  endtask

  // Inputs change on falling edges, so the rising edge sees a settled transfer
  always @(posedge clk) begin
    if (!rst && retire_valid_i && retire_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Core retired an instruction at pc %h that was never sent", retire_i.pc);
        fail_count_o <= fail_count_o + 1;
      end else begin
        exp_rec = exp_q.pop_front();
        errors  = 0;
        compare_field("pc", exp_rec.pc, retire_i.pc, checked_o);
        compare_field("wen", 32'(exp_rec.wen), 32'(retire_i.wen), checked_o);
        if (exp_rec.wen) begin // rd and wdata only mean something on a write
          compare_field("rd", 32'(exp_rec.rd), 32'(retire_i.rd), checked_o);
          compare_field("wdata", exp_rec.wdata, retire_i.wdata, checked_o);
        end
        compare_field("taken", 32'(exp_rec.taken), 32'(retire_i.taken), checked_o);
        compare_field("target", exp_rec.target, retire_i.target, checked_o);
        compare_field("illegal", 32'(exp_rec.illegal), 32'(retire_i.illegal), checked_o);
        if (errors == 0) begin
          $display("record %0d pc %h ok", checked_o, retire_i.pc);
          pass_count_o <= pass_count_o + 1;
        end else begin
          $display("record %0d pc %h has %0d mismatches", checked_o, retire_i.pc, errors);
          fail_count_o <= fail_count_o + 1;
        end
        checked_o <= checked_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int REC_WORDS      = 8;
  localparam int MEM_WORDS      = 512;
  localparam int TIMEOUT_CYCLES = 200;

  logic                clk = 1'b0;
  logic                rst;
  logic [`RV_ILEN-1:0] inst;
  logic [`RV_XLEN-1:0] pc;
  logic                in_valid;
  logic                in_ready;
  retire_t             retire;
  logic                retire_valid;
  logic                retire_ready = 1'b0;
  integer              seed = 47;
  logic [31:0]         tdata [0:MEM_WORDS-1];
  int                  pass_count;
  int                  fail_count;
  int                  checked;
  int                  sent;
  int                  base;
  bit                  hung;
  retire_t             exp_rec;

  always #10 clk = ~clk;

  always @(negedge clk) begin
    retire_ready = ($random(seed) % 4) != 0; // Ready about three cycles in four
  end

  rv_core_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .inst_i         (inst),
    .pc_i           (pc),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .retire_o       (retire),
    .retire_valid_o (retire_valid),
    .retire_ready_i (retire_ready)
  );

  tb_rv_checker u_check (
    .clk            (clk),
    .rst            (rst),
    .retire_i       (retire),
    .retire_valid_i (retire_valid),
    .retire_ready_i (retire_ready),
    .pass_count_o   (pass_count),
    .fail_count_o   (fail_count),
    .checked_o      (checked)
  );

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_instruction(input logic [31:0] pc_val, input logic [31:0] inst_val);
    int cycles;
    bit accepted;
    cycles   = 0;
    accepted = 1'b0;
    pc       = pc_val;
    inst     = inst_val;
    in_valid = 1'b1;
    while (!accepted && !hung) begin
      #1;
      accepted = in_ready; // Transfer on the coming rising edge
      @(negedge clk);
      cycles++;
      if (!accepted && cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: core never accepted the instruction at pc %h", pc_val);
        hung = 1'b1;
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_for_retires();
    int cycles;
    cycles = 0;
    while (checked < sent && !hung) begin
      @(negedge clk);
      cycles++;
      if (checked < sent && cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: only %0d of %0d instructions retired", checked, sent);
        hung = 1'b1;
      end
    end
  endtask

  initial begin
    rst      = 1'b1;
    inst     = '0;
    pc       = '0;
    in_valid = 1'b0;
    hung     = 1'b0;
    sent     = 0;
    base     = 0;
    $readmemh("rv_testdata.txt", tdata);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // A pc of all ones ends the record list
    while (!hung && base + REC_WORDS <= MEM_WORDS && tdata[base] != 32'hFFFF_FFFF) begin
      exp_rec.pc      = tdata[base];
      exp_rec.rd      = tdata[base+2][`RV_REG_AW-1:0];
      exp_rec.wdata   = tdata[base+3];
      exp_rec.wen     = tdata[base+4][0];
      exp_rec.taken   = tdata[base+5][0];
      exp_rec.target  = tdata[base+6];
      exp_rec.illegal = tdata[base+7][0];
      u_check.add_expected(exp_rec);
      send_instruction(tdata[base], tdata[base+1]);
      sent++;
      base += REC_WORDS;
    end
    wait_for_retires();
    $display("Summary: %0d passed, %0d failed, %0d of %0d retired",
             pass_count, fail_count, checked, sent);
    if (!hung && fail_count == 0 && checked == sent && sent > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_checker.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_rv_core -f sim.f \
  && ./obj_dir/Vtb_rv_core | tee /dev/stderr | grep "^Simulation passed$" > /dev/null \
  && echo "Run completed without errors" \
  || { echo "Run reported errors"; exit 1; }

// ==== rv_testdata.txt ====
// pc inst rd wdata wen taken target illegal, all hex, one record per line
// rd and wdata are only compared when wen is 1, a pc of ffffffff ends the list
00000100 800000b7 1 80000000 1 0 00000104 0 // lui x1, 0x80000
00000104 ffb00113 2 fffffffb 1 0 00000108 0 // addi x2, x0, -5
00000108 00700193 3 00000007 1 0 0000010c 0 // addi x3, x0, 7
0000010c 00310233 4 00000002 1 0 00000110 0 // add x4, x2, x3
00000110 402182b3 5 0000000c 1 0 00000114 0 // sub x5, x3, x2
00000114 00312333 6 00000001 1 0 00000118 0 // slt x6, x2, x3
00000118 003133b3 7 00000000 1 0 0000011c 0 // sltu x7, x2, x3
0000011c 4030d433 8 ff000000 1 0 00000120 0 // sra x8, x1, x3
00000120 0030d4b3 9 01000000 1 0 00000124 0 // srl x9, x1, x3
00000124 00319533 a 00000380 1 0 00000128 0 // sll x10, x3, x3
00000128 003145b3 b fffffffc 1 0 0000012c 0 // xor x11, x2, x3
0000012c 0030e633 c 80000007 1 0 00000130 0 // or x12, x1, x3
00000130 003176b3 d 00000003 1 0 00000134 0 // and x13, x2, x3
00000134 ffc12713 e 00000001 1 0 00000138 0 // slti x14, x2, -4
00000138 fff1b793 f 00000001 1 0 0000013c 0 // sltiu x15, x3, -1
0000013c 0f024213 4 000000f2 1 0 00000140 0 // xori x4, x4, 0xf0
00000140 10026293 5 000001f2 1 0 00000144 0 // ori x5, x4, 0x100
00000144 0ff2f313 6 000000f2 1 0 00000148 0 // andi x6, x5, 0xff
00000148 00431393 7 00000f20 1 0 0000014c 0 // slli x7, x6, 4
0000014c 40115413 8 fffffffd 1 0 00000150 0 // srai x8, x2, 1
00000150 00115493 9 7ffffffd 1 0 00000154 0 // srli x9, x2, 1
00000154 00518013 0 00000000 0 0 00000158 0 // addi x0, x3, 5
00000158 40700533 a fffff0e0 1 0 0000015c 0 // sub x10, x0, x7
0000015c 00a185b3 b fffff0e7 1 0 00000160 0 // add x11, x3, x10
00000160 12345617 c 12345160 1 0 00000164 0 // auipc x12, 0x12345
00000164 abcde6b7 d abcde000 1 0 00000168 0 // lui x13, 0xabcde
00000168 0200076f e 0000016c 1 1 00000188 0 // jal x14, +32
0000016c ff9ff7ef f 00000170 1 1 00000164 0 // jal x15, -8
00000170 003600e7 1 00000174 1 1 12345162 0 // jalr x1, 3(x12)
00000174 fff68167 2 00000178 1 1 abcddffe 0 // jalr x2, -1(x13)
00000178 00620863 0 00000000 0 1 00000188 0 // beq x4, x6, +16
0000017c 00621863 0 00000000 0 0 00000180 0 // bne x4, x6, +16
00000180 fe3448e3 0 00000000 0 1 00000170 0 // blt x8, x3, -16
00000184 00345863 0 00000000 0 0 00000188 0 // bge x8, x3, +16
00000188 00346863 0 00000000 0 0 0000018c 0 // bltu x8, x3, +16
0000018c fe3478e3 0 00000000 0 1 0000017c 0 // bgeu x8, x3, -16
00000190 00320863 0 00000000 0 0 00000194 0 // beq x4, x3, +16
00000194 00321863 0 00000000 0 1 000001a4 0 // bne x4, x3, +16
00000198 0081c863 0 00000000 0 0 0000019c 0 // blt x3, x8, +16
0000019c 0081d863 0 00000000 0 1 000001ac 0 // bge x3, x8, +16
000001a0 0081e863 0 00000000 0 1 000001b0 0 // bltu x3, x8, +16
000001a4 0081f863 0 00000000 0 0 000001a8 0 // bgeu x3, x8, +16
000001a8 00022183 0 00000000 0 0 000001ac 1 // lw x3, 0(x4)
000001ac 00322023 0 00000000 0 0 000001b0 1 // sw x3, 0(x4)
000001b0 00000073 0 00000000 0 0 000001b4 1 // ecall
000001b4 000001ff 0 00000000 0 0 000001b8 1 // unknown opcode, rd x3
000001b8 00118293 5 00000008 1 0 000001bc 0 // addi x5, x3, 1
ffffffff 00000000 0 00000000 0 0 00000000 0 // end of list
